//--- Makefile
SIM = obj_dir/Vtb_box_overlay

all: run

$(SIM): box_overlay.f src/*.sv tests/tb_box_overlay.sv
	verilator --binary --timing --assert -Wno-fatal -f box_overlay.f \
		--top-module tb_box_overlay -o Vtb_box_overlay

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing -Wall -f box_overlay.f --top-module box_overlay_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- box_overlay.f
src/box_overlay_pkg.sv
src/box_table_if.sv
src/frame_box_sampler.sv
src/box_area_filter.sv
src/border_hit_detect.sv
src/pixel_compositor.sv
src/box_overlay_top.sv
tests/tb_box_overlay.sv

//--- src/border_hit_detect.sv
`timescale 1ns/1ps

module border_hit_detect import box_overlay_pkg::*; (
    input  coord_t      draw_x_i,
    input  coord_t      draw_y_i,
    box_table_if.border boxes,
    output logic        border_hit_o
);

    region_mask_t hits;

    always_comb begin
        logic in_x;
        logic in_y;
        logic on_row;
        logic on_col;

        for (int r = 0; r < NUM_REGIONS; r++) begin
            in_x   = (draw_x_i >= boxes.min_x[r]) && (draw_x_i <= boxes.max_x[r]);
            in_y   = (draw_y_i >= boxes.min_y[r]) && (draw_y_i <= boxes.max_y[r]);
            // Top or bottom edge
            on_row = ((draw_y_i == boxes.min_y[r]) || (draw_y_i == boxes.max_y[r])) && in_x;
            // Left or right edge
            on_col = ((draw_x_i == boxes.min_x[r]) || (draw_x_i == boxes.max_x[r])) && in_y;
            hits[r] = boxes.valid_mask[r] && (on_row || on_col);
        end
    end

    // Overlaps just OR together
    assign border_hit_o = |hits;

endmodule

//--- src/box_area_filter.sv
`timescale 1ns/1ps

module box_area_filter import box_overlay_pkg::*; (
    input  thresh_t     thresh_i,
    box_table_if.filter boxes
);

    area_t area [NUM_REGIONS];
    area_t eff_thresh;

    // Zero selects the default
    assign eff_thresh = (thresh_i == '0) ? AREA_THRESH_DEFAULT : area_t'(thresh_i);

    for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
        logic             present;
        logic [COORD_W:0] width;
        logic [COORD_W:0] height;

        assign present = (boxes.min_x[r] != COORD_NONE) &&
                         (boxes.max_x[r] >= boxes.min_x[r]) &&
                         (boxes.min_y[r] != COORD_NONE) &&
                         (boxes.max_y[r] >= boxes.min_y[r]);

        // Inclusive spans
        assign width  = {1'b0, boxes.max_x[r]} - {1'b0, boxes.min_x[r]} + 1'b1;
        assign height = {1'b0, boxes.max_y[r]} - {1'b0, boxes.min_y[r]} + 1'b1;

        assign area[r] = present ? (area_t'(width) * area_t'(height)) : '0;
    end

    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            boxes.valid_mask[r] = (area[r] >= eff_thresh);
        end
    end

endmodule

//--- src/box_overlay_pkg.sv
package box_overlay_pkg;

    // Widths
    localparam int COORD_W     = 10;
    localparam int GRAY_W      = 7;
    localparam int GAIN_W      = 7;
    localparam int CAM_PIXEL_W = 8;
    localparam int AREA_W      = 22;
    localparam int THRESH_W    = 15;
    localparam int REGION_W    = 4;
    localparam int FRAME_CNT_W = 3;

    // Region grid, 4 columns by 3 rows
    localparam int REGION_COLS = 4;
    localparam int REGION_ROWS = 3;
    localparam int NUM_REGIONS = REGION_COLS * REGION_ROWS;

    typedef logic [COORD_W-1:0]     coord_t;
    typedef logic [GRAY_W-1:0]      gray_t;
    typedef logic [GAIN_W-1:0]      gain_t;
    typedef logic [CAM_PIXEL_W-1:0] cam_pixel_t;
    typedef logic [AREA_W-1:0]      area_t;
    typedef logic [THRESH_W-1:0]    thresh_t;
    typedef logic [REGION_W-1:0]    region_idx_t;
    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;
    typedef logic [NUM_REGIONS-1:0] region_mask_t;

    // Minimum of a region in which the detector found nothing
    localparam coord_t COORD_NONE = coord_t'(641);

    localparam int    FRAMES_PER_LATCH    = 5;
    localparam area_t AREA_THRESH_DEFAULT = area_t'(16);
    localparam int    GAIN_SHIFT          = 7;
    localparam gray_t CHANNEL_FULL        = '1;

    typedef enum logic {
        WAIT_FRAMES,
        LATCH
    } sampler_state_t;

endpackage

//--- src/box_overlay_top.sv
`timescale 1ns/1ps

module box_overlay_top import box_overlay_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // Region writes from the detector
    input  logic        region_we_i,
    input  region_idx_t region_idx_i,
    input  coord_t      region_min_x_i,
    input  coord_t      region_max_x_i,
    input  coord_t      region_min_y_i,
    input  coord_t      region_max_y_i,
    input  logic        vsync_i,
    // Display pixel
    input  logic        pixel_valid_i,
    input  coord_t      draw_x_i,
    input  coord_t      draw_y_i,
    input  cam_pixel_t  cam_pixel_i,
    input  gain_t       gain_i,
    input  thresh_t     thresh_i,
    input  logic        highlight_i,
    output logic        pixel_valid_o,
    output gray_t       red_o,
    output gray_t       green_o,
    output gray_t       blue_o
);

    logic border_hit;

    box_table_if boxes ();

    frame_box_sampler u_sampler (
        .clk            (clk),
        .reset          (reset),
        .region_we_i    (region_we_i),
        .region_idx_i   (region_idx_i),
        .region_min_x_i (region_min_x_i),
        .region_max_x_i (region_max_x_i),
        .region_min_y_i (region_min_y_i),
        .region_max_y_i (region_max_y_i),
        .vsync_i        (vsync_i),
        .boxes          (boxes.sampler)
    );

    box_area_filter u_filter (
        .thresh_i (thresh_i),
        .boxes    (boxes.filter)
    );

    border_hit_detect u_border (
        .draw_x_i     (draw_x_i),
        .draw_y_i     (draw_y_i),
        .boxes        (boxes.border),
        .border_hit_o (border_hit)
    );

    pixel_compositor u_compositor (
        .clk           (clk),
        .reset         (reset),
        .pixel_valid_i (pixel_valid_i),
        .cam_pixel_i   (cam_pixel_i),
        .gain_i        (gain_i),
        .border_hit_i  (border_hit),
        .highlight_i   (highlight_i),
        .pixel_valid_o (pixel_valid_o),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o)
    );

endmodule

//--- src/box_table_if.sv
`timescale 1ns/1ps

interface box_table_if import box_overlay_pkg::*; ();

    // Displayed table, one entry per region
    coord_t min_x [NUM_REGIONS];
    coord_t max_x [NUM_REGIONS];
    coord_t min_y [NUM_REGIONS];
    coord_t max_y [NUM_REGIONS];

    // Boxes that pass the area filter
    region_mask_t valid_mask;

    modport sampler (
        output min_x, max_x, min_y, max_y
    );

    modport filter (
        input  min_x, max_x, min_y, max_y,
        output valid_mask
    );

    modport border (
        input min_x, max_x, min_y, max_y, valid_mask
    );

endinterface

//--- src/frame_box_sampler.sv
`timescale 1ns/1ps

module frame_box_sampler import box_overlay_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        region_we_i,
    input  region_idx_t region_idx_i,
    input  coord_t      region_min_x_i,
    input  coord_t      region_max_x_i,
    input  coord_t      region_min_y_i,
    input  coord_t      region_max_y_i,
    input  logic        vsync_i,
    box_table_if.sampler boxes
);

    coord_t live_min_x [NUM_REGIONS];
    coord_t live_max_x [NUM_REGIONS];
    coord_t live_min_y [NUM_REGIONS];
    coord_t live_max_y [NUM_REGIONS];

    logic           vsync_q1;
    logic           vsync_q2;
    logic           frame_edge;
    frame_cnt_t     frame_cnt;
    sampler_state_t state;

    //////////////////////////////////////////////////
    // Live table, written by the detector
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGIONS; r++) begin
                live_min_x[r] <= COORD_NONE;
                live_max_x[r] <= '0;
                live_min_y[r] <= COORD_NONE;
                live_max_y[r] <= '0;
            end
        end else if (region_we_i && (region_idx_i < region_idx_t'(NUM_REGIONS))) begin
            live_min_x[region_idx_i] <= region_min_x_i;
            live_max_x[region_idx_i] <= region_max_x_i;
            live_min_y[region_idx_i] <= region_min_y_i;
            live_max_y[region_idx_i] <= region_max_y_i;
        end
    end

    //////////////////////////////////////////////////
    // Frame edge and every-fifth-frame latch
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vsync_q1 <= 1'b0;
            vsync_q2 <= 1'b0;
        end else begin
            vsync_q1 <= vsync_i;
            vsync_q2 <= vsync_q1;
        end
    end

    // Falling vsync
    assign frame_edge = vsync_q2 & ~vsync_q1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= WAIT_FRAMES;
            frame_cnt <= '0;
        end else begin
            state <= WAIT_FRAMES;
            if (frame_edge) begin
                if (frame_cnt == frame_cnt_t'(FRAMES_PER_LATCH - 1)) begin
                    state     <= LATCH;
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGIONS; r++) begin
                boxes.min_x[r] <= COORD_NONE;
                boxes.max_x[r] <= '0;
                boxes.min_y[r] <= COORD_NONE;
                boxes.max_y[r] <= '0;
            end
        end else if (state == LATCH) begin
            boxes.min_x <= live_min_x;
            boxes.max_x <= live_max_x;
            boxes.min_y <= live_min_y;
            boxes.max_y <= live_max_y;
        end
    end

    a_frame_cnt_range: assert property (@(posedge clk) disable iff (reset)
        frame_cnt <= frame_cnt_t'(FRAMES_PER_LATCH - 1));

endmodule

//--- src/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor import box_overlay_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pixel_valid_i,
    input  cam_pixel_t cam_pixel_i,
    input  gain_t      gain_i,
    input  logic       border_hit_i,
    input  logic       highlight_i,
    output logic       pixel_valid_o,
    output gray_t      red_o,
    output gray_t      green_o,
    output gray_t      blue_o
);

    logic [GRAY_W+GAIN_W-1:0] product;
    gray_t                    scaled;
    logic                     paint_red;

    //////////////////////////////////////////////////
    // Brightness, fixed point gain over 128
    //////////////////////////////////////////////////
    assign product = cam_pixel_i[CAM_PIXEL_W-1:1] * gain_i;
    assign scaled  = gray_t'(product >> GAIN_SHIFT);

    assign paint_red = border_hit_i & highlight_i;

    //////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pixel_valid_o <= 1'b0;
            red_o         <= '0;
            green_o       <= '0;
            blue_o        <= '0;
        end else begin
            pixel_valid_o <= pixel_valid_i;
            if (paint_red) begin
                red_o   <= CHANNEL_FULL;
                green_o <= '0;
                blue_o  <= '0;
            end else begin
                red_o   <= scaled;
                green_o <= scaled;
                blue_o  <= scaled;
            end
        end
    end

    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        pixel_valid_o == $past(pixel_valid_i));

endmodule

//--- tests/box_overlay_golden.txt
# N count | W idx min_x max_x min_y max_y | F one frame
# P x y cam gain thresh highlight red green blue, all decimal
N 50
# After reset no box is valid
P 10 20 200 127 0 1 99 99 99
P 320 240 255 0 0 1 0 0 0
P 0 0 255 127 0 1 126 126 126
P 639 479 128 64 0 1 32 32 32
P 100 50 77 100 0 1 29 29 29
P 11 21 1 127 9 1 0 0 0
P 200 200 180 90 0 1 63 63 63
# Region 0 is 4x4, region 1 is 3x3
W 0 10 13 20 23
W 1 100 102 50 52
F
F
F
F
P 10 20 200 127 0 1 99 99 99
P 100 50 200 127 9 1 99 99 99
# Fifth frame latches the live table
F
P 10 20 200 127 0 1 127 0 0
P 100 50 200 127 0 1 99 99 99
P 100 50 200 127 9 1 127 0 0
P 102 52 200 127 9 1 127 0 0
# Edges and corners of region 0
P 11 20 200 127 0 1 127 0 0
P 12 23 200 127 0 1 127 0 0
P 10 22 200 127 0 1 127 0 0
P 13 21 200 127 0 1 127 0 0
P 13 23 200 127 0 1 127 0 0
P 10 23 200 127 0 1 127 0 0
P 13 20 200 127 0 1 127 0 0
P 11 21 100 64 0 1 25 25 25
P 12 22 100 64 0 1 25 25 25
P 9 20 100 64 0 1 25 25 25
P 14 21 100 64 0 1 25 25 25
P 11 19 100 64 0 1 25 25 25
P 12 24 100 64 0 1 25 25 25
P 10 20 100 64 0 0 25 25 25
# Invalid boxes, and region 5 overlapping region 0
W 2 641 300 100 110
W 3 400 390 200 210
W 4 500 510 300 290
W 5 12 30 22 40
F
F
F
F
F
P 300 105 200 127 0 1 99 99 99
P 400 205 200 127 0 1 99 99 99
P 505 300 200 127 0 1 99 99 99
P 12 23 200 127 0 1 127 0 0
P 12 22 200 127 0 1 127 0 0
P 30 40 200 127 0 1 127 0 0
P 20 30 200 127 0 1 99 99 99

//--- tests/tb_box_overlay.sv
`timescale 1ns/1ps

module tb_box_overlay;

    localparam GOLDEN_PATH = "tests/box_overlay_golden.txt";

    logic        clk;
    logic        reset;
    logic        region_we_i;
    logic [3:0]  region_idx_i;
    logic [9:0]  region_min_x_i;
    logic [9:0]  region_max_x_i;
    logic [9:0]  region_min_y_i;
    logic [9:0]  region_max_y_i;
    logic        vsync_i;
    logic        pixel_valid_i;
    logic [9:0]  draw_x_i;
    logic [9:0]  draw_y_i;
    logic [7:0]  cam_pixel_i;
    logic [6:0]  gain_i;
    logic [14:0] thresh_i;
    logic        highlight_i;
    logic        pixel_valid_o;
    logic [6:0]  red_o;
    logic [6:0]  green_o;
    logic [6:0]  blue_o;

    int          check_count;
    int          mismatch_count;
    int          other_errors;
    int          command_count;
    int unsigned watchdog_cycles;
    logic        watchdog_armed;

    box_overlay_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .region_we_i    (region_we_i),
        .region_idx_i   (region_idx_i),
        .region_min_x_i (region_min_x_i),
        .region_max_x_i (region_max_x_i),
        .region_min_y_i (region_min_y_i),
        .region_max_y_i (region_max_y_i),
        .vsync_i        (vsync_i),
        .pixel_valid_i  (pixel_valid_i),
        .draw_x_i       (draw_x_i),
        .draw_y_i       (draw_y_i),
        .cam_pixel_i    (cam_pixel_i),
        .gain_i         (gain_i),
        .thresh_i       (thresh_i),
        .highlight_i    (highlight_i),
        .pixel_valid_o  (pixel_valid_o),
        .red_o          (red_o),
        .green_o        (green_o),
        .blue_o         (blue_o)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            mismatch_count++;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Drivers, all changes on the falling edge
    //////////////////////////////////////////////////
    task automatic write_region(input int idx, input int mnx, input int mxx,
                                input int mny, input int mxy);
        @(negedge clk);
        region_we_i    = 1'b1;
        region_idx_i   = idx[3:0];
        region_min_x_i = mnx[9:0];
        region_max_x_i = mxx[9:0];
        region_min_y_i = mny[9:0];
        region_max_y_i = mxy[9:0];
        @(negedge clk);
        region_we_i = 1'b0;
    endtask

    // vsync high then low, 4 cycles each
    task automatic run_frame();
        @(negedge clk);
        vsync_i = 1'b1;
        repeat (4) @(negedge clk);
        vsync_i = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic check_pixel(input int x, input int y, input int cam, input int gain,
                               input int thresh, input int hl, input int exp_r,
                               input int exp_g, input int exp_b);
        string tag;

        @(negedge clk);
        pixel_valid_i = 1'b1;
        draw_x_i      = x[9:0];
        draw_y_i      = y[9:0];
        cam_pixel_i   = cam[7:0];
        gain_i        = gain[6:0];
        thresh_i      = thresh[14:0];
        highlight_i   = hl[0];
        // One register stage in the compositor
        @(negedge clk);
        pixel_valid_i = 1'b0;
        tag = $sformatf("pixel (%0d,%0d)", x, y);
        check_value({tag, " valid"}, int'(pixel_valid_o), 1);
        check_value({tag, " red"}, int'(red_o), exp_r);
        check_value({tag, " green"}, int'(green_o), exp_g);
        check_value({tag, " blue"}, int'(blue_o), exp_b);
    endtask

    //////////////////////////////////////////////////
    // Golden file reader
    //////////////////////////////////////////////////
    task automatic run_golden();
        int               fd;
        byte              cmd;
        int               code;
        int               n_expected;
        int               v [9];
        logic [8*160-1:0] rest;

        n_expected = -1;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the golden file %s", GOLDEN_PATH);
            return;
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else if (cmd == "N") begin
                code = $fscanf(fd, "%d", n_expected);
                if (code != 1 || n_expected < 0) begin
                    other_errors++;
                    $display("The N line of the golden file holds no valid count");
                    break;
                end
                watchdog_cycles = n_expected * 20 + 200;
                watchdog_armed  = 1'b1;
            end else if (n_expected < 0) begin
                other_errors++;
                $display("The golden file has a command before its N line");
                break;
            end else begin
                command_count++;
                if (cmd == "W") begin
                    code = $fscanf(fd, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
                    if (code != 5) begin
                        other_errors++;
                        $display("Golden command %0d: W needs five numbers", command_count);
                        break;
                    end
                    write_region(v[0], v[1], v[2], v[3], v[4]);
                end else if (cmd == "F") begin
                    run_frame();
                end else if (cmd == "P") begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                                   v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (code != 9) begin
                        other_errors++;
                        $display("Golden command %0d: P needs nine numbers", command_count);
                        break;
                    end
                    check_pixel(v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                end else begin
                    other_errors++;
                    $display("Golden command %0d has an unknown letter %c", command_count, cmd);
                    break;
                end
            end
        end
        $fclose(fd);
        if (n_expected < 0) begin
            other_errors++;
            $display("The golden file has no N line");
        end else if (command_count != n_expected) begin
            other_errors++;
            $display("The golden file holds %0d commands but its N line says %0d",
                     command_count, n_expected);
        end
    endtask

    initial begin
        reset          = 1'b1;
        region_we_i    = 1'b0;
        region_idx_i   = '0;
        region_min_x_i = '0;
        region_max_x_i = '0;
        region_min_y_i = '0;
        region_max_y_i = '0;
        vsync_i        = 1'b0;
        pixel_valid_i  = 1'b0;
        draw_x_i       = '0;
        draw_y_i       = '0;
        cam_pixel_i    = '0;
        gain_i         = '0;
        thresh_i       = '0;
        highlight_i    = 1'b0;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        command_count  = 0;
        watchdog_armed = 1'b0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("pixel_valid_o after reset", int'(pixel_valid_o), 0);
        check_value("red_o after reset", int'(red_o), 0);
        check_value("green_o after reset", int'(green_o), 0);
        check_value("blue_o after reset", int'(blue_o), 0);

        run_golden();

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog, armed once the command count is known
    initial begin
        wait (watchdog_armed === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired: the golden commands did not finish within %0d cycles",
                 watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
